// ==== dv/montgomery_tb.sv ====
`timescale 1ns/1ps

module montgomery_tb;

  localparam int unsigned NUM_VEC     = 12;
  localparam int unsigned NUM_RANDOM  = 24;
  localparam int unsigned DRAIN_LIMIT = 100;  // Cycles allowed for the pipe to empty.

  typedef struct packed {
    logic [7:0]                         gap;          // Idle cycles after the request.
    logic [montgomery_pkg::DATA_W-1:0]  modulus;
    logic [montgomery_pkg::KBITS_W-1:0] k;
    logic [montgomery_pkg::DATA_W-1:0]  m_inv;
    logic [montgomery_pkg::WIDE_W-1:0]  t;
    logic [montgomery_pkg::DATA_W-1:0]  expected;
    logic                               has_exp;      // Random requests have none.
    logic [31:0]                        start_cycle;
  } req_vec_t;

  logic                               clk_i;
  logic                               rst_ni;
  logic                               start;
  logic [montgomery_pkg::WIDE_W-1:0]  x;
  logic [montgomery_pkg::DATA_W-1:0]  modulus;
  logic [montgomery_pkg::KBITS_W-1:0] k;
  logic [montgomery_pkg::DATA_W-1:0]  m_inv;
  logic                               valid;
  logic [montgomery_pkg::DATA_W-1:0]  result;

  req_vec_t    vectors [NUM_VEC];
  req_vec_t    pending [$];  // Oldest request in flight first.
  int unsigned error_count;
  int unsigned test_count;
  logic [31:0] cycle_cnt;

  montgomery_top i_dut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (start),
    .x_i       (x),
    .modulus_i (modulus),
    .k_i       (k),
    .m_inv_i   (m_inv),
    .valid_o   (valid),
    .result_o  (result)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR at time %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual,
               expected);
      error_count++;
    end
  endtask

  function automatic req_vec_t make_vec(input int gap, input logic [31:0] m, input int kb,
                                        input logic [31:0] inv, input logic [63:0] t,
                                        input logic [31:0] exp_r);
    req_vec_t v;
    v.gap         = gap[7:0];
    v.modulus     = m;
    v.k           = kb[montgomery_pkg::KBITS_W-1:0];
    v.m_inv       = inv;
    v.t           = t;
    v.expected    = exp_r;
    v.has_exp     = 1'b1;
    v.start_cycle = '0;
    return v;
  endfunction

  // Expected values are T * 2^-k mod M.
  task automatic fill_table();
    vectors[0]  = make_vec(0, 13, 4, 11, 100, 3);
    vectors[1]  = make_vec(0, 7, 3, 1, 50, 1);
    vectors[2]  = make_vec(0, 97, 8, 95, 1000, 13);
    vectors[3]  = make_vec(0, 3, 1, 1, 5, 1);
    vectors[4]  = make_vec(0, 32'hffff_ffff, 32, 1, 64'h0000_0005_0000_0007, 12);
    vectors[5]  = make_vec(0, 32'h8000_0001, 32, 32'h7fff_ffff, 64'h0000_0003_8000_0001, 3);
    vectors[6]  = make_vec(0, 32'h0000_ffff, 16, 1, 64'h0000_0000_1234_5678, 32'h68ac);
    vectors[7]  = make_vec(1, 13, 4, 11, 0, 0);                // T = 0.
    vectors[8]  = make_vec(3, 97, 8, 95, 97, 0);               // T = M.
    vectors[9]  = make_vec(2, 13, 4, 11, 207, 4);              // T = M*R - 1.
    vectors[10] = make_vec(1, 32'hffff_ffff, 32, 1, 64'hffff_fffe_ffff_ffff, 32'hffff_fffe);
    vectors[11] = make_vec(0, 32'h8000_0001, 32, 32'h7fff_ffff, 64'h8000_0000_ffff_ffff,
                           32'h4000_0001);
  endtask

  task automatic send_request(input req_vec_t v);
    start         = 1'b1;
    x             = v.t;
    modulus       = v.modulus;
    k             = v.k;
    m_inv         = v.m_inv;
    v.start_cycle = cycle_cnt;
    pending.push_back(v);
    @(posedge clk_i);
    #1;
    start = 1'b0;
    repeat (v.gap) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic check_result();
    req_vec_t    v;
    int unsigned errors_before;
    logic [63:0] scaled;
    logic [63:0] mod_wide;
    if (pending.size() == 0) begin
      $display("Unexpected valid_o pulse at time %0t with no request outstanding.", $time);
      error_count++;
    end else begin
      errors_before = error_count;
      v        = pending.pop_front();
      mod_wide = {32'b0, v.modulus};
      scaled   = {32'b0, result} << v.k;  // Result times 2^k fits in 64 bits.
      check_value(cycle_cnt - v.start_cycle, montgomery_pkg::LATENCY, "latency to valid_o");
      if (v.has_exp) begin
        check_value(result, v.expected, "result against table");
      end
      check_value(result < v.modulus, 1, "result below modulus");
      check_value(scaled % mod_wide, v.t % mod_wide, "result * 2^k congruent to T mod M");
      test_count++;
      $display("Test %0d: M=0x%0h k=%0d T=0x%0h result=0x%0h %s", test_count, v.modulus,
               v.k, v.t, result, (error_count == errors_before) ? "ok" : "FAILED");
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_ni && valid) begin
      check_result();
    end
  end

  initial begin
    req_vec_t    v;
    logic [64:0] bound;
    int unsigned idx;
    int unsigned drain_cycles;
    int unsigned errors_before;
    rst_ni      = 1'b0;
    start       = 1'b0;
    x           = '0;
    modulus     = '0;
    k           = '0;
    m_inv       = '0;
    error_count = 0;
    test_count  = 0;
    void'($urandom(39));
    fill_table();
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    errors_before = error_count;
    repeat (4) begin
      @(negedge clk_i);
      check_value(valid, 0, "valid_o idle after reset");
      check_value(result, 0, "result_o zero after reset");
    end
    test_count++;
    $display("Test %0d: outputs idle after reset %s", test_count,
             (error_count == errors_before) ? "ok" : "FAILED");
    @(posedge clk_i);
    #1;
    foreach (vectors[i]) begin
      send_request(vectors[i]);
    end
    // Random T below M*R with the table's moduli.
    for (int n = 0; n < NUM_RANDOM; n++) begin
      idx       = $urandom % NUM_VEC;
      v         = vectors[idx];
      bound     = {33'b0, v.modulus} << v.k;
      v.t       = {$urandom, $urandom} % bound[63:0];
      v.gap     = 8'($urandom % 3);
      v.has_exp = 1'b0;
      send_request(v);
    end
    drain_cycles = 0;
    while (pending.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
      @(posedge clk_i);
      drain_cycles++;
    end
    if (pending.size() != 0) begin
      $display("Timeout: %0d results still outstanding after %0d cycles.", pending.size(),
               DRAIN_LIMIT);
      error_count++;
    end
    repeat (montgomery_pkg::LATENCY + 4) @(posedge clk_i);  // Catches stray pulses.
    $display("Tests run: %0d, errors: %0d", test_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
source/montgomery_pkg.sv
source/pipe_multiplier.sv
source/reduction_chain.sv
source/operand_delay.sv
source/montgomery_finalize.sv
source/montgomery_top.sv
dv/montgomery_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the Montgomery reduction testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module montgomery_tb \
  -f filelist.f \
  --Mdir obj_dir \
  -o montgomery_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed."
  exit 1
fi

output=$(./obj_dir/montgomery_sim)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
  exit 0
fi

echo "Pass message not found in simulation output."
exit 1

// ==== source/montgomery_finalize.sv ====
`timescale 1ns/1ps

module montgomery_finalize (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              valid_i,
  input  logic                              delay_valid_i,
  input  logic [montgomery_pkg::WIDE_W-1:0] qm_i,
  input  montgomery_pkg::mont_carry_t       carry_i,
  output logic                              valid_o,
  output logic [montgomery_pkg::DATA_W-1:0] result_o
);

  logic [montgomery_pkg::WIDE_W:0] sum_full;  // T + qM with carry bit.
  logic [montgomery_pkg::WIDE_W:0] sum_shr;
  logic [montgomery_pkg::DATA_W:0] red_q;     // Below 2M.
  logic [montgomery_pkg::DATA_W:0] mod_ext;
  logic [montgomery_pkg::DATA_W:0] diff;
  logic [montgomery_pkg::DATA_W-1:0] mod_q;
  logic                              vld1_q;

  // Low k bits of the sum are zero by construction of q.
  assign sum_full = {1'b0, carry_i.t} + {1'b0, qm_i};
  assign sum_shr  = sum_full >> carry_i.k;

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      red_q <= sum_shr[montgomery_pkg::DATA_W:0];
      mod_q <= carry_i.modulus;
    end
  end

  assign mod_ext = {1'b0, mod_q};
  assign diff    = red_q - mod_ext;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld1_q   <= 1'b0;
      valid_o  <= 1'b0;
      result_o <= '0;
    end else begin
      vld1_q  <= valid_i;
      valid_o <= vld1_q;
      if (vld1_q) begin
        // One conditional subtract.
        result_o <= (red_q >= mod_ext) ? diff[montgomery_pkg::DATA_W-1:0]
                                       : red_q[montgomery_pkg::DATA_W-1:0];
      end
    end
  end

  // Multiply chain and operand delay must stay in lockstep.
  a_paths_aligned : assert property (
    @(posedge clk_i) disable iff (!rst_ni) valid_i == delay_valid_i
  ) else $error("Chain and delay line out of step.");

  a_result_reduced : assert property (
    @(posedge clk_i) disable iff (!rst_ni) valid_o |-> (result_o < $past(mod_q))
  ) else $error("Result not below its modulus.");

endmodule

// ==== source/montgomery_pkg.sv ====
package montgomery_pkg;

  // Operand widths.
  localparam int unsigned DATA_W  = 32;                 // Modulus, M' and result.
  localparam int unsigned WIDE_W  = 2 * DATA_W;         // T and full products.
  localparam int unsigned KBITS_W = $clog2(DATA_W + 1); // Holds k up to DATA_W.

  // Pipeline depths, counted in register stages.
  localparam int unsigned MUL_STAGES    = 3;                  // Per multiplier.
  localparam int unsigned CHAIN_LATENCY = 2 * MUL_STAGES;     // Two multipliers.
  localparam int unsigned LATENCY       = CHAIN_LATENCY + 2;  // Plus finalize.

  // Request as it enters the unit.
  typedef struct packed {
    logic [WIDE_W-1:0]  t;        // Value to reduce.
    logic [DATA_W-1:0]  modulus;  // Odd modulus M.
    logic [KBITS_W-1:0] k;        // Radix exponent.
    logic [DATA_W-1:0]  m_inv;    // -M^-1 mod 2^k.
  } mont_req_t;

  // Fields still needed after the multiply chain.
  typedef struct packed {
    logic [WIDE_W-1:0]  t;
    logic [DATA_W-1:0]  modulus;
    logic [KBITS_W-1:0] k;
  } mont_carry_t;

endpackage

// ==== source/montgomery_top.sv ====
`timescale 1ns/1ps

module montgomery_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               start_i,
  input  logic [montgomery_pkg::WIDE_W-1:0]  x_i,
  input  logic [montgomery_pkg::DATA_W-1:0]  modulus_i,
  input  logic [montgomery_pkg::KBITS_W-1:0] k_i,
  input  logic [montgomery_pkg::DATA_W-1:0]  m_inv_i,
  output logic                               valid_o,
  output logic [montgomery_pkg::DATA_W-1:0]  result_o
);

  montgomery_pkg::mont_req_t         req;
  montgomery_pkg::mont_carry_t       carry_in;
  montgomery_pkg::mont_carry_t       carry_dly;
  logic [montgomery_pkg::WIDE_W-1:0] qm;
  logic                              chain_valid;
  logic                              delay_valid;

  assign req.t       = x_i;
  assign req.modulus = modulus_i;
  assign req.k       = k_i;
  assign req.m_inv   = m_inv_i;

  assign carry_in.t       = req.t;
  assign carry_in.modulus = req.modulus;
  assign carry_in.k       = req.k;

  reduction_chain i_chain (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (start_i),
    .req_i   (req),
    .valid_o (chain_valid),
    .qm_o    (qm)
  );

  operand_delay i_delay (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (start_i),
    .carry_i (carry_in),
    .valid_o (delay_valid),
    .carry_o (carry_dly)
  );

  montgomery_finalize i_finalize (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .valid_i       (chain_valid),
    .delay_valid_i (delay_valid),
    .qm_i          (qm),
    .carry_i       (carry_dly),
    .valid_o       (valid_o),
    .result_o      (result_o)
  );

endmodule

// ==== source/operand_delay.sv ====
`timescale 1ns/1ps

module operand_delay (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        valid_i,
  input  montgomery_pkg::mont_carry_t carry_i,
  output logic                        valid_o,
  output montgomery_pkg::mont_carry_t carry_o
);

  montgomery_pkg::mont_carry_t              carry_q [montgomery_pkg::CHAIN_LATENCY];
  logic [montgomery_pkg::CHAIN_LATENCY-1:0] vld_q;

  // Payload columns, no reset.
  always_ff @(posedge clk_i) begin
    carry_q[0] <= carry_i;
    for (int i = 1; i < montgomery_pkg::CHAIN_LATENCY; i++) begin
      carry_q[i] <= carry_q[i-1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[montgomery_pkg::CHAIN_LATENCY-2:0], valid_i};
    end
  end

  assign valid_o = vld_q[montgomery_pkg::CHAIN_LATENCY-1];
  assign carry_o = carry_q[montgomery_pkg::CHAIN_LATENCY-1];  // Lines up with qm.

endmodule

// ==== source/pipe_multiplier.sv ====
`timescale 1ns/1ps

module pipe_multiplier (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              valid_i,
  input  logic [montgomery_pkg::DATA_W-1:0] a_i,
  input  logic [montgomery_pkg::DATA_W-1:0] b_i,
  output logic                              valid_o,
  output logic [montgomery_pkg::WIDE_W-1:0] p_o
);

  logic [montgomery_pkg::DATA_W-1:0]     a_q;    // Operand stage.
  logic [montgomery_pkg::DATA_W-1:0]     b_q;
  logic [montgomery_pkg::WIDE_W-1:0]     a_ext;
  logic [montgomery_pkg::WIDE_W-1:0]     b_ext;
  logic [montgomery_pkg::WIDE_W-1:0]     prod_q [montgomery_pkg::MUL_STAGES-1];
  logic [montgomery_pkg::MUL_STAGES-1:0] vld_q;  // One bit per stage.

  assign a_ext = {{montgomery_pkg::DATA_W{1'b0}}, a_q};
  assign b_ext = {{montgomery_pkg::DATA_W{1'b0}}, b_q};

  // Each stage holds its own item.
  always_ff @(posedge clk_i) begin
    a_q       <= a_i;
    b_q       <= b_i;
    prod_q[0] <= a_ext * b_ext;  // Full product.
    for (int i = 1; i < montgomery_pkg::MUL_STAGES - 1; i++) begin
      prod_q[i] <= prod_q[i-1];  // Retiming stages.
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[montgomery_pkg::MUL_STAGES-2:0], valid_i};
    end
  end

  assign valid_o = vld_q[montgomery_pkg::MUL_STAGES-1];
  assign p_o     = prod_q[montgomery_pkg::MUL_STAGES-2];

  // The product leaves together with the valid bit of its own operands.
  a_valid_delay : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    valid_o |->
      (p_o == $past(a_i, montgomery_pkg::MUL_STAGES) *
              $past(b_i, montgomery_pkg::MUL_STAGES))
  ) else $error("Multiplier product out of step with its valid bit.");

endmodule

// ==== source/reduction_chain.sv ====
`timescale 1ns/1ps

module reduction_chain (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              valid_i,
  input  montgomery_pkg::mont_req_t         req_i,
  output logic                              valid_o,
  output logic [montgomery_pkg::WIDE_W-1:0] qm_o
);

  logic [montgomery_pkg::DATA_W-1:0]  t_low;      // T mod R.
  logic                               mul1_valid;
  logic [montgomery_pkg::WIDE_W-1:0]  mul1_p;     // (T mod R) * M'.
  logic [montgomery_pkg::DATA_W-1:0]  q;
  logic [montgomery_pkg::DATA_W-1:0]  mod_q [montgomery_pkg::MUL_STAGES];
  logic [montgomery_pkg::KBITS_W-1:0] k_q   [montgomery_pkg::MUL_STAGES];

  // Ones in the low k bits, all ones when k equals DATA_W.
  function automatic logic [montgomery_pkg::DATA_W-1:0] low_mask(
    input logic [montgomery_pkg::KBITS_W-1:0] bits
  );
    logic [montgomery_pkg::DATA_W:0] one_hot;
    one_hot = {{montgomery_pkg::DATA_W{1'b0}}, 1'b1} << bits;
    return one_hot[montgomery_pkg::DATA_W-1:0] - 1'b1;
  endfunction

  // k never exceeds DATA_W, so the low word of T is enough.
  assign t_low = req_i.t[montgomery_pkg::DATA_W-1:0] & low_mask(req_i.k);

  pipe_multiplier i_mul_q (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (valid_i),
    .a_i     (t_low),
    .b_i     (req_i.m_inv),
    .valid_o (mul1_valid),
    .p_o     (mul1_p)
  );

  // Modulus and k follow the first multiplier.
  always_ff @(posedge clk_i) begin
    mod_q[0] <= req_i.modulus;
    k_q[0]   <= req_i.k;
    for (int i = 1; i < montgomery_pkg::MUL_STAGES; i++) begin
      mod_q[i] <= mod_q[i-1];
      k_q[i]   <= k_q[i-1];
    end
  end

  assign q = mul1_p[montgomery_pkg::DATA_W-1:0] &
             low_mask(k_q[montgomery_pkg::MUL_STAGES-1]);  // Product mod R.

  pipe_multiplier i_mul_qm (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (mul1_valid),
    .a_i     (q),
    .b_i     (mod_q[montgomery_pkg::MUL_STAGES-1]),
    .valid_o (valid_o),
    .p_o     (qm_o)
  );

endmodule
